// ==== src/cmd_settings.svh ====
/* Build-time sizes for the command packet processor
   Stream word width and register file geometry */
`ifndef CMD_SETTINGS_SVH
`define CMD_SETTINGS_SVH

// Width of every stream word and of each register
`define CMD_DATA_W 32

// Register file depth
`define CMD_REG_COUNT 16
// Register index, taken from the low bits of the address word
`define CMD_ADDR_W 4

`endif

// ==== src/cmd_pkg.sv ====
/* Shared types of the command packet processor
   Opcode and response code encodings, receive beat,
   command header, executor result and response record,
   plus the state encodings of the three stages */
package cmd_pkg;
	`include "cmd_settings.svh"

	// Opcode from the low byte of the CC word
	typedef enum logic [7:0] {
		OP_NOP   = 8'h00,
		OP_WRITE = 8'h01,
		OP_READ  = 8'h02,
		OP_SUM   = 8'h03
	} cmd_opcode_e;

	// Response code, zero-extended onto the RC word
	typedef enum logic [7:0] {
		RC_OK      = 8'h00,
		RC_ILLEGAL = 8'h01,
		RC_LENGTH  = 8'h02
	} resp_code_e;

	// One receive stream beat
	typedef struct packed {
		logic [`CMD_DATA_W-1:0]   data;
		logic [`CMD_DATA_W/8-1:0] keep;
		logic                     last;
	} rx_beat_t;

	// Latched CSN and opcode, 40 bits
	typedef struct packed {
		logic [`CMD_DATA_W-1:0] csn;
		cmd_opcode_e            opcode;
	} cmd_header_t;

	// What the executor hands back; rdc is 0 or 1
	typedef struct packed {
		resp_code_e             code;
		logic                   rdc;
		logic [`CMD_DATA_W-1:0] rd1;
	} exec_result_t;

	// A whole response as seen by the framer
	typedef struct packed {
		logic [`CMD_DATA_W-1:0] rsn;
		exec_result_t           result;
	} resp_t;

	typedef enum logic [3:0] {
		S_IDLE, S_RESYNC, S_LATCH_CSN, S_WAIT_CC, S_LATCH_CC, S_START_CC,
		S_PAUSE, S_TEST_RUNNING, S_WAIT_FOR_DONE, S_DONE, S_ILLEGAL_CC
	} seq_state_e;

	typedef enum logic [2:0] {
		E_IDLE, E_START, E_CDC, E_DATA, E_DONE
	} exec_state_e;

	typedef enum logic [2:0] {
		F_IDLE, F_RSN, F_RC, F_RDC, F_RD1
	} frame_state_e;
endpackage

// ==== src/command_sequencer.sv ====
/* Command sequencer
   Latches CSN and CC from the receive stream, starts the executor,
   treats a missing start as an illegal command and drains its packet,
   then holds the response record until the framer takes it */
`include "cmd_settings.svh"

module command_sequencer import cmd_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  rx_beat_t     rx_beat,
	input  logic         rx_valid,
	output logic         rx_ready,
	output cmd_header_t  header,
	output logic         run,
	input  logic         running,
	input  logic         done,
	input  exec_result_t result,
	output resp_t        resp,
	output logic         resp_valid,
	input  logic         resp_ready
);

	seq_state_e state;
	seq_state_e state_n;

	// Valid last beat where the sequencer itself is reading
	logic last_seen;

	assign last_seen = rx_valid && rx_beat.last;

	always_ff @(posedge clk) begin
		if (reset)
			state <= S_IDLE;
		else
			state <= state_n;
	end

	always_comb begin
		state_n = state;
		case (state)
			// A stray last beat here means we lost sync, throw it away
			S_IDLE: begin
				if (last_seen)
					state_n = S_RESYNC;
				else if (rx_valid)
					state_n = S_LATCH_CSN;
			end
			S_RESYNC:    state_n = S_IDLE;
			S_LATCH_CSN: state_n = S_WAIT_CC;
			// Packet ending at CC carries no command
			S_WAIT_CC: begin
				if (last_seen)
					state_n = S_RESYNC;
				else if (rx_valid)
					state_n = S_LATCH_CC;
			end
			S_LATCH_CC: state_n = S_START_CC;
			S_START_CC: state_n = S_PAUSE;
			// Executor gets one cycle to raise running
			S_PAUSE:    state_n = S_TEST_RUNNING;
			S_TEST_RUNNING: begin
				if (running)
					state_n = S_WAIT_FOR_DONE;
				else
					state_n = S_ILLEGAL_CC;
			end
			S_WAIT_FOR_DONE: begin
				if (done)
					state_n = S_DONE;
			end
			// Nobody took the command, drain to last
			S_ILLEGAL_CC: begin
				if (last_seen)
					state_n = S_DONE;
			end
			S_DONE: begin
				if (resp_ready)
					state_n = S_IDLE;
			end
			default: state_n = S_IDLE;
		endcase
	end

	// Header and response registers
	always_ff @(posedge clk) begin
		if (state == S_LATCH_CSN)
			header.csn <= rx_beat.data;
		if (state == S_LATCH_CC)
			header.opcode <= cmd_opcode_e'(rx_beat.data[7:0]);
		if (state == S_WAIT_FOR_DONE && done) begin
			resp.rsn    <= header.csn;
			resp.result <= result;
		end
		if (state == S_ILLEGAL_CC && last_seen) begin
			resp.rsn    <= header.csn;
			resp.result <= '{code: RC_ILLEGAL, rdc: 1'b0, rd1: '0};
		end
	end

	// Receive ownership outside the executor's data phase
	assign rx_ready = (state == S_RESYNC) || (state == S_LATCH_CSN) ||
		(state == S_LATCH_CC) || (state == S_ILLEGAL_CC);

	// run stays up until the executor reports done
	assign run = (state == S_START_CC) || (state == S_PAUSE) ||
		(state == S_TEST_RUNNING) || (state == S_WAIT_FOR_DONE);

	assign resp_valid = (state == S_DONE);

	// Link carries whole words only
	a_full_keep: assert property (@(posedge clk) disable iff (reset)
		rx_valid |-> rx_beat.keep == '1);

	// Record must not move under the framer before it is taken
	a_resp_stable: assert property (@(posedge clk) disable iff (reset)
		resp_valid && !resp_ready |=> resp_valid && $stable(resp));

endmodule

// ==== src/command_executor.sv ====
/* Command executor
   Starts on a rising run for known opcodes, reads CDC and data words
   until last, checks the count, runs WRITE, READ, SUM or NOP against
   its register file and pulses done with the result */
`include "cmd_settings.svh"

module command_executor import cmd_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  cmd_header_t  header,
	input  logic         run,
	input  rx_beat_t     rx_beat,
	input  logic         rx_valid,
	output logic         rx_ready,
	output logic         running,
	output logic         done,
	output exec_result_t result
);

	exec_state_e state;
	logic run_q;
	logic start, legal_op, accept, finish, in_data, rule_ok, len_ok;

	logic [`CMD_DATA_W-1:0] regs [`CMD_REG_COUNT];
	logic [`CMD_DATA_W-1:0] cdc_q, count_q, sum_q, word0_q, word1_q;
	logic [`CMD_DATA_W-1:0] cdc_n, count_n, sum_n, word0_n, word1_n;
	logic [`CMD_ADDR_W-1:0] addr;
	exec_result_t res_n;

	// Unknown opcodes never start, the sequencer sees running stay low
	assign legal_op = header.opcode inside {OP_NOP, OP_WRITE, OP_READ, OP_SUM};
	assign start    = run && !run_q && legal_op;

	// Beats are taken only after the sequencer has checked running
	assign rx_ready = (state == E_CDC) || (state == E_DATA);
	assign accept   = rx_valid && rx_ready;
	assign finish   = accept && rx_beat.last;
	assign in_data  = (state == E_DATA);
	assign running  = (state != E_IDLE);
	assign done     = (state == E_DONE);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= E_IDLE;
			run_q <= 1'b0;
		end else begin
			run_q <= run;
			case (state)
				E_IDLE:  if (start) state <= E_START;
				E_START: state <= E_CDC;
				E_CDC:   if (accept) state <= rx_beat.last ? E_DONE : E_DATA;
				E_DATA:  if (finish) state <= E_DONE;
				E_DONE:  state <= E_IDLE;
				default: state <= E_IDLE;
			endcase
		end
	end

	// Values including the beat on the bus, so the last word counts too
	assign cdc_n   = (state == E_CDC) ? rx_beat.data : cdc_q;
	assign count_n = in_data ? count_q + 1 : count_q;
	assign sum_n   = in_data ? sum_q + rx_beat.data : sum_q;
	assign word0_n = (in_data && count_q == 0) ? rx_beat.data : word0_q;
	assign word1_n = (in_data && count_q == 1) ? rx_beat.data : word1_q;
	assign addr    = word0_n[`CMD_ADDR_W-1:0];

	// Data count each opcode allows
	always_comb begin
		case (header.opcode)
			OP_NOP:   rule_ok = (count_n == 0);
			OP_WRITE: rule_ok = (count_n == 2);
			OP_READ:  rule_ok = (count_n == 1);
			default:  rule_ok = (count_n != 0);
		endcase
	end
	assign len_ok = rule_ok && (cdc_n == count_n);

	always_comb begin
		res_n = '{code: RC_OK, rdc: 1'b0, rd1: '0};
		if (!len_ok) begin
			res_n.code = RC_LENGTH;
		end else if (header.opcode == OP_READ) begin
			res_n.rdc = 1'b1;
			res_n.rd1 = regs[addr];
		end else if (header.opcode == OP_SUM) begin
			res_n.rdc = 1'b1;
			res_n.rd1 = sum_n;
		end
	end

	// Datapath and register file
	always_ff @(posedge clk) begin
		if (state == E_START) begin
			count_q <= '0;
			sum_q   <= '0;
		end
		if (accept) begin
			cdc_q   <= cdc_n;
			count_q <= count_n;
			sum_q   <= sum_n;
			word0_q <= word0_n;
			word1_q <= word1_n;
		end
		// Result held until the next command finishes
		if (finish)
			result <= res_n;
		if (finish && len_ok && header.opcode == OP_WRITE)
			regs[addr] <= word1_n;
	end

	// Sequencer keeps run up for the whole command
	a_done_running: assert property (@(posedge clk) disable iff (reset)
		done |-> $past(running) && run);

endmodule

// ==== src/response_framer.sv ====
/* Response framer
   Takes one response record and sends RSN, RC, RDC and,
   when RDC is 1, RD1 on the transmit stream, last on the final word */
`include "cmd_settings.svh"

module response_framer import cmd_pkg::*; (
	input  logic                   clk,
	input  logic                   reset,
	input  resp_t                  resp,
	input  logic                   resp_valid,
	output logic                   resp_ready,
	output logic [`CMD_DATA_W-1:0] tx_data,
	output logic                   tx_last,
	output logic                   tx_valid,
	input  logic                   tx_ready
);

	frame_state_e state;
	resp_t resp_q;

	assign resp_ready = (state == F_IDLE);
	assign tx_valid   = (state != F_IDLE);

	// Advance one word per accepted transfer
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= F_IDLE;
		end else begin
			case (state)
				F_IDLE:  if (resp_valid) state <= F_RSN;
				F_RSN:   if (tx_ready) state <= F_RC;
				F_RC:    if (tx_ready) state <= F_RDC;
				F_RDC:   if (tx_ready) state <= resp_q.result.rdc ? F_RD1 : F_IDLE;
				F_RD1:   if (tx_ready) state <= F_IDLE;
				default: state <= F_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (resp_valid && resp_ready)
			resp_q <= resp;
	end

	// Word select, driven only from state and the held record
	always_comb begin
		case (state)
			F_RSN:   tx_data = resp_q.rsn;
			F_RC:    tx_data = {{(`CMD_DATA_W-8){1'b0}}, resp_q.result.code};
			F_RDC:   tx_data = {{(`CMD_DATA_W-1){1'b0}}, resp_q.result.rdc};
			F_RD1:   tx_data = resp_q.result.rd1;
			default: tx_data = '0;
		endcase
	end

	// RDC closes the packet unless RD1 follows
	assign tx_last = (state == F_RD1) || (state == F_RDC && !resp_q.result.rdc);

	a_tx_hold: assert property (@(posedge clk) disable iff (reset)
		tx_valid && !tx_ready |=> tx_valid && $stable(tx_data) && $stable(tx_last));

endmodule

// ==== src/command_processor.sv ====
/* Command processor top level
   Chains sequencer, executor and framer between the
   receive and transmit streams */
`include "cmd_settings.svh"

module command_processor import cmd_pkg::*; (
	input  logic                   clk,
	input  logic                   reset,
	input  rx_beat_t               rx_beat,
	input  logic                   rx_valid,
	output logic                   rx_ready,
	output logic [`CMD_DATA_W-1:0] tx_data,
	output logic                   tx_last,
	output logic                   tx_valid,
	input  logic                   tx_ready
);

	logic seq_rx_ready, exec_rx_ready;
	logic run, running, done;
	logic resp_valid, resp_ready;
	cmd_header_t header;
	exec_result_t result;
	resp_t resp;

	// Only one stage owns the receive stream at a time
	assign rx_ready = seq_rx_ready | exec_rx_ready;

	command_sequencer seq0 (
		.clk(clk), .reset(reset), .rx_beat(rx_beat), .rx_valid(rx_valid),
		.rx_ready(seq_rx_ready), .header(header), .run(run), .running(running),
		.done(done), .result(result), .resp(resp), .resp_valid(resp_valid),
		.resp_ready(resp_ready));

	command_executor exec0 (
		.clk(clk), .reset(reset), .header(header), .run(run), .rx_beat(rx_beat),
		.rx_valid(rx_valid), .rx_ready(exec_rx_ready), .running(running),
		.done(done), .result(result));

	response_framer frame0 (
		.clk(clk), .reset(reset), .resp(resp), .resp_valid(resp_valid),
		.resp_ready(resp_ready), .tx_data(tx_data), .tx_last(tx_last),
		.tx_valid(tx_valid), .tx_ready(tx_ready));

endmodule

// ==== tests/command_processor_tb.sv ====
/* Testbench for the command processor
   Table of command packets with expected responses, a packet driver
   with random gaps, random tx_ready back-pressure, a response checker
   and a watchdog */
`include "cmd_settings.svh"

module command_processor_tb import cmd_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_ROWS = 12;
	localparam int MAX_WORDS = 6;
	localparam int CYCLES_PER_ROW = 200;
	localparam int CLK_PERIOD = 4;

	logic clk;
	logic reset;
	rx_beat_t rx_beat;
	logic rx_valid;
	logic rx_ready;
	logic [`CMD_DATA_W-1:0] tx_data;
	logic tx_last;
	logic tx_valid;
	logic tx_ready;

	// Stimulus table with one entry per test
	string row_name [NUM_ROWS];
	logic [`CMD_DATA_W-1:0] row_words [NUM_ROWS][MAX_WORDS];
	int row_len [NUM_ROWS];
	logic [7:0] row_rc [NUM_ROWS];
	logic row_rdc [NUM_ROWS];
	logic [`CMD_DATA_W-1:0] row_rd1 [NUM_ROWS];
	bit row_silent [NUM_ROWS];

	integer seed = 35422;
	int sent_count = 0;
	int pass_count = 0;
	int fail_count = 0;
	string word_name [4] = '{"RSN", "RC", "RDC", "RD1"};

	command_processor dut0 (
		.clk(clk), .reset(reset), .rx_beat(rx_beat), .rx_valid(rx_valid),
		.rx_ready(rx_ready), .tx_data(tx_data), .tx_last(tx_last),
		.tx_valid(tx_valid), .tx_ready(tx_ready));

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Back-pressure with ready about three cycles in four
	always @(posedge clk) begin
		#1;
		tx_ready <= (($random(seed) & 3) != 0);
	end

	task automatic add_row(input int idx, input string name, input int len,
		input logic [31:0] w0, input logic [31:0] w1, input logic [31:0] w2,
		input logic [31:0] w3, input logic [31:0] w4, input logic [31:0] w5,
		input resp_code_e rc, input logic rdc, input logic [31:0] rd1, input bit silent);
		row_name[idx] = name;
		row_len[idx] = len;
		row_words[idx][0] = w0;
		row_words[idx][1] = w1;
		row_words[idx][2] = w2;
		row_words[idx][3] = w3;
		row_words[idx][4] = w4;
		row_words[idx][5] = w5;
		row_rc[idx] = rc;
		row_rdc[idx] = rdc;
		row_rd1[idx] = rd1;
		row_silent[idx] = silent;
	endtask

	task automatic load_table();
		// Words are CSN, CC, CDC and data with unused slots zero
		add_row(0, "write_r3", 5, 'h101, 1, 2, 3, 'hcafe_f00d, 0, RC_OK, 0, 0, 0);
		add_row(1, "read_r3", 4, 'h102, 2, 1, 3, 0, 0, RC_OK, 1, 'hcafe_f00d, 0);
		add_row(2, "nop", 3, 'h103, 0, 0, 0, 0, 0, RC_OK, 0, 0, 0);
		// Sum wraps past 32 bits
		add_row(3, "sum3", 6, 'h104, 3, 3, 'hffff_fff0, 'h20, 5, RC_OK, 1, 'h15, 0);
		add_row(4, "illegal_op", 5, 'h105, 'h55, 2, 1, 2, 0, RC_ILLEGAL, 0, 0, 0);
		add_row(5, "read_after_illegal", 4, 'h106, 2, 1, 3, 0, 0, RC_OK, 1, 'hcafe_f00d, 0);
		// Stray last words are dropped without a response
		add_row(6, "lone_last", 1, 'h999, 0, 0, 0, 0, 0, RC_OK, 0, 0, 1);
		add_row(7, "end_at_cc", 2, 'h107, 1, 0, 0, 0, 0, RC_OK, 0, 0, 1);
		add_row(8, "cdc_mismatch", 4, 'h108, 3, 2, 7, 0, 0, RC_LENGTH, 0, 0, 0);
		add_row(9, "read_cdc2", 5, 'h109, 2, 2, 3, 4, 0, RC_LENGTH, 0, 0, 0);
		add_row(10, "write_r9", 5, 'h10a, 1, 2, 9, 'h1234_5678, 0, RC_OK, 0, 0, 0);
		add_row(11, "read_r9", 4, 'h10b, 2, 1, 9, 0, 0, RC_OK, 1, 'h1234_5678, 0);
	endtask

	// Drives one packet and holds each beat until rx_ready takes it
	task automatic send_packet(input int idx);
		int i;
		int gap;
		for (i = 0; i < row_len[idx]; i++) begin
			gap = $random(seed) & 1;
			repeat (gap) begin
				@(posedge clk);
				#1;
			end
			rx_beat.data = row_words[idx][i];
			rx_beat.keep = '1;
			rx_beat.last = (i == row_len[idx] - 1);
			rx_valid = 1'b1;
			// Ready depends on state only and is stable at the falling edge
			@(negedge clk);
			while (!rx_ready)
				@(negedge clk);
			@(posedge clk);
			#1;
			rx_valid = 1'b0;
		end
	endtask

	// Collects one response packet and compares it word by word
	task automatic check_response(input int idx);
		logic [`CMD_DATA_W-1:0] got [4];
		logic [`CMD_DATA_W-1:0] expected [4];
		int n;
		int exp_n;
		int i;
		bit last_flag;
		bit ok;
		expected[0] = row_words[idx][0];
		expected[1] = {{(`CMD_DATA_W-8){1'b0}}, row_rc[idx]};
		expected[2] = {{(`CMD_DATA_W-1){1'b0}}, row_rdc[idx]};
		expected[3] = row_rd1[idx];
		exp_n = row_rdc[idx] ? 4 : 3;
		n = 0;
		last_flag = 0;
		ok = 1;
		while (!last_flag && n < 4) begin
			@(negedge clk);
			if (tx_valid && tx_ready) begin
				got[n] = tx_data;
				last_flag = tx_last;
				n++;
			end
		end
		if (!last_flag) begin
			$display("%s: response ran past four words without last", row_name[idx]);
			ok = 0;
		end else if (n != exp_n) begin
			$display("FAIL %s word count expected %0d actual %0d", row_name[idx], exp_n, n);
			ok = 0;
		end else begin
			for (i = 0; i < n; i++) begin
				if (got[i] != expected[i]) begin
					$display("FAIL %s %s expected %h actual %h",
						row_name[idx], word_name[i], expected[i], got[i]);
					ok = 0;
				end
			end
		end
		if (ok) begin
			$display("PASS %s", row_name[idx]);
			pass_count++;
		end else begin
			fail_count++;
		end
	endtask

	// A dropped packet leaves the transmit side idle until the next packet is in
	task automatic confirm_dropped(input int idx);
		int sent_goal;
		bit quiet;
		sent_goal = (idx + 1 < NUM_ROWS) ? idx + 2 : idx + 1;
		quiet = 1;
		while (sent_count < sent_goal) begin
			@(negedge clk);
			if (tx_valid)
				quiet = 0;
		end
		if (quiet) begin
			$display("PASS %s (dropped, no response)", row_name[idx]);
			pass_count++;
		end else begin
			$display("%s: a response came out for a dropped packet", row_name[idx]);
			fail_count++;
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		rx_valid = 1'b0;
		rx_beat = '0;
		tx_ready = 1'b0;
		load_table();
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		fork
			begin
				for (int r = 0; r < NUM_ROWS; r++) begin
					repeat ($random(seed) & 3) begin
						@(posedge clk);
						#1;
					end
					send_packet(r);
					sent_count++;
				end
			end
			begin
				for (int r = 0; r < NUM_ROWS; r++) begin
					if (row_silent[r])
						confirm_dropped(r);
					else
						check_response(r);
				end
			end
		join
		// Nothing more may come out once every packet is answered
		repeat (40) begin
			@(negedge clk);
			if (tx_valid) begin
				$display("Unexpected response word after the final test");
				fail_count++;
				break;
			end
		end
		$display("Tests %0d, passed %0d, failed %0d", NUM_ROWS, pass_count, fail_count);
		if (fail_count == 0 && pass_count == NUM_ROWS)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	// Watchdog scaled by table length
	initial begin
		#((NUM_ROWS * CYCLES_PER_ROW + 10) * CLK_PERIOD);
		$display("Timeout: responses did not arrive within %0d cycles",
			NUM_ROWS * CYCLES_PER_ROW);
		$display("TB FAILED");
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+src
src/cmd_pkg.sv
src/command_sequencer.sv
src/command_executor.sv
src/response_framer.sv
src/command_processor.sv
tests/command_processor_tb.sv

// ==== Makefile ====
.PHONY: all run lint clean

all: run

obj_dir/sim: files.f src/*.sv src/*.svh tests/*.sv
	verilator --binary --timing --assert --top-module command_processor_tb \
		-f files.f -Mdir obj_dir -o sim

run: obj_dir/sim
	./obj_dir/sim > sim.log 2>&1 || true
	cat sim.log
	grep -qx "TB PASSED" sim.log

lint:
	verilator --lint-only --timing --top-module command_processor -f files.f

clean:
	rm -rf obj_dir sim.log
